// ==== tb.f ====
common/pmrq_pkg.sv
pmrq/pmrq_alloc.sv
pmrq/pmrq_entry.sv
pmrq/pmrq_retire.sv
pmrq/pending_mem_req_queue.sv
testbench/clk_gen.sv
testbench/pmrq_assertions.sv
testbench/tb_pmrq.sv

// ==== testbench/tb_pmrq.sv ====
// ==============================
// Testbench of the pending memory request queue
// Directed phases and a random mix
// Reference queue checks finish order and data
// ==============================

module tb_pmrq;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 2000;    // ~8 reset plus ~400 stimulus cycles, wide margin

    logic                          clk;
    logic                          rstn;
    pmrq_pkg::mem_instr_t          instruction;
    logic [pmrq_pkg::TAG_W-1:0]    tag;
    pmrq_pkg::replay_t             replay;
    logic                          flush;
    logic                          advance_head;
    pmrq_pkg::mem_instr_t          finish_instr;
    logic                          full;

    // Reference queue, oldest first
    pmrq_pkg::mem_instr_t          m_instr [$];
    logic [pmrq_pkg::TAG_W-1:0]    m_tag   [$];
    logic                          m_ready [$];

    logic [pmrq_pkg::TAG_W-1:0]    live_tags [$];  // Tags handed out in this phase
    logic [pmrq_pkg::TAG_W-1:0]    order     [$];
    logic [pmrq_pkg::TAG_W-1:0]    t;
    logic [31:0]                   rnd;
    integer                        seed;
    int                            j;
    int                            cycles = 0;

    clk_gen u_clk (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    pending_mem_req_queue uut (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .instruction_i  (instruction),
        .tag_i          (tag),
        .replay_i       (replay),
        .flush_i        (flush),
        .advance_head_i (advance_head),
        .finish_instr_o (finish_instr),
        .full_o         (full)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // One clock of stimulus, random payload on a write
    task automatic drive_cycle(input logic wr, input logic [pmrq_pkg::TAG_W-1:0] wtag,
                               input logic rp, input logic [pmrq_pkg::TAG_W-1:0] rtag,
                               input logic fl, input logic adv);
        pmrq_pkg::mem_instr_t ins;
        pmrq_pkg::replay_t    rpl;
        logic [31:0]          r;
        ins = '0;
        rpl = '0;
        if (wr) begin
            r            = $random(seed);
            ins.valid    = 1'b1;
            ins.rd       = r[4:0];
            ins.mem_op   = pmrq_pkg::mem_op_t'({r[5], 1'b0, r[7:6]});  // Legal encodings only
            ins.addr     = {r[15:8], 32'($random(seed))};
            ins.data_rs2 = {32'($random(seed)), 32'($random(seed))};
        end
        if (rp) begin
            rpl.valid = 1'b1;
            rpl.tag   = rtag;
            rpl.data  = {32'($random(seed)), 32'($random(seed))};
        end
        @(posedge clk);
        instruction  <= ins;
        tag          <= wtag;
        replay       <= rpl;
        flush        <= fl;
        advance_head <= adv;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    // Random tag not yet used in this phase
    task automatic new_tag(output logic [pmrq_pkg::TAG_W-1:0] nt);
        logic dup;
        do begin
            nt  = 7'($random(seed));
            dup = 1'b0;
            foreach (live_tags[i]) begin
                if (live_tags[i] == nt) dup = 1'b1;
            end
        end while (dup);
        live_tags.push_back(nt);
    endtask

    task automatic write_new();
        logic [pmrq_pkg::TAG_W-1:0] nt;
        new_tag(nt);
        drive_cycle(1'b1, nt, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic replay_tag(input logic [pmrq_pkg::TAG_W-1:0] rt);
        drive_cycle(1'b0, '0, 1'b1, rt, 1'b0, 1'b0);
    endtask

    // Wait for finish valid, then retire the head, run timeout bounds the wait
    task automatic retire_when_done();
        idle(1);
        @(negedge clk);
        while (!finish_instr.valid) begin
            idle(1);
            @(negedge clk);
        end
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
    endtask

    // Expected finish from the reference queue
    task automatic check_finish();
        pmrq_pkg::mem_instr_t exp;
        exp = '0;
        if (m_instr.size() > 0 && m_ready[0]) exp = m_instr[0];
        if (finish_instr !== exp) begin
            abort_run($sformatf("** Error at %0t ns: finish_instr_o is %h, expected %h",
                                $time, finish_instr, exp));
        end
    endtask

    // Apply the inputs the DUT captures at the coming edge
    task automatic update_model();
        logic room;
        room = (m_instr.size() < pmrq_pkg::PMRQ_NUM_ENTRIES);  // Count before this edge
        if (flush) begin
            m_instr.delete();
            m_tag.delete();
            m_ready.delete();
        end else begin
            if (replay.valid) begin
                foreach (m_tag[i]) begin
                    if (m_tag[i] == replay.tag) begin
                        m_ready[i]          = 1'b1;
                        m_instr[i].data_rs2 = replay.data;
                    end
                end
            end
            if (advance_head && m_instr.size() > 0) begin
                void'(m_instr.pop_front());
                void'(m_tag.pop_front());
                void'(m_ready.pop_front());
            end
            if (instruction.valid && room) begin   // New slot not matched by this replay
                m_instr.push_back(instruction);
                m_tag.push_back(tag);
                m_ready.push_back(1'b0);
            end
        end
    endtask

    // Mid-cycle, everything settled
    always @(negedge clk) begin
        if (uut.u_assert.fail_cnt != 0) begin
            abort_run("a bound assertion on the queue failed");
        end else if (rstn) begin
            check_finish();
            update_model();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) abort_run("timeout, test did not finish");
    end

    initial begin
        seed         = 32'hea9e;
        instruction  = '0;
        tag          = '0;
        replay       = '0;
        flush        = 1'b0;
        advance_head = 1'b0;
        wait (rstn === 1'b1);
        idle(2);

        // Five writes, wakeup in shuffled order
        live_tags.delete();
        repeat (5) write_new();
        order = live_tags;
        for (int i = 4; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[i]) replay_tag(order[i]);
        repeat (5) retire_when_done();

        // Fill to depth, ninth write dropped
        live_tags.delete();
        repeat (9) write_new();
        for (int i = 0; i < pmrq_pkg::PMRQ_NUM_ENTRIES; i++) replay_tag(live_tags[i]);
        repeat (8) retire_when_done();

        // Old tag after retire must not wake the waiting entry
        live_tags.delete();
        repeat (2) write_new();
        replay_tag(live_tags[0]);
        retire_when_done();
        replay_tag(live_tags[0]);
        idle(3);
        replay_tag(live_tags[1]);
        retire_when_done();

        // Flush with ready entries, then a fresh write
        live_tags.delete();
        repeat (3) write_new();
        foreach (live_tags[i]) replay_tag(live_tags[i]);
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        idle(2);
        live_tags.delete();
        write_new();
        replay_tag(live_tags[0]);
        retire_when_done();

        // Write and retire together, head not yet woken
        live_tags.delete();
        repeat (2) write_new();
        new_tag(t);
        drive_cycle(1'b1, t, 1'b0, '0, 1'b0, 1'b1);
        replay_tag(live_tags[1]);
        replay_tag(t);
        repeat (2) retire_when_done();

        // Random mix, small tag range so replays can wake several slots
        repeat (150) begin
            rnd = $random(seed);
            drive_cycle(rnd[0], {4'h0, rnd[3:1]}, rnd[4], {4'h0, rnd[7:5]},
                        rnd[13:8] == 6'h00, rnd[15:14] == 2'b00);
        end
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        idle(3);

        if (uut.u_assert.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("bound assertions reported failures");
        end
    end

endmodule

// ==== testbench/pmrq_assertions.sv ====
// ==============================
// Concurrent checks on the queue
// Reset outputs, finish gating, full level
// Count bound, flush and write with retire
// ==============================

module pmrq_assertions (
    input logic                                clk_i,
    input logic                                rstn_i,
    input logic                                flush_i,
    input logic                                full_i,       // DUT full_o
    input pmrq_pkg::mem_instr_t                finish_i,     // DUT finish_instr_o
    input logic [pmrq_pkg::PMRQ_CNT_W-1:0]     count_i,      // Allocator occupancy
    input logic                                write_en_i,
    input logic                                advance_en_i,
    input pmrq_pkg::pmrq_entry_t               head_entry_i, // Slot at the head pointer
    input pmrq_pkg::pmrq_entry_t               entries_i [pmrq_pkg::PMRQ_NUM_ENTRIES]
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FULL_LEVEL = pmrq_pkg::PMRQ_NUM_ENTRIES - pmrq_pkg::PMRQ_FULL_MARGIN;

    int unsigned fail_cnt = 0;   // Failures so far, polled by the testbench

    logic [pmrq_pkg::PMRQ_CNT_W-1:0] live_cnt;  // Occupied bits summed over all slots

    always_comb begin
        live_cnt = '0;
        for (int i = 0; i < pmrq_pkg::PMRQ_NUM_ENTRIES; i++) begin
            live_cnt = live_cnt + pmrq_pkg::PMRQ_CNT_W'(entries_i[i].occupied);
        end
    end

    // In reset: full high, nothing finishing
    reset_out: assert property (@(posedge clk_i) !rstn_i |-> full_i && !finish_i.valid)
        else begin
            fail_cnt++;
            $error("outputs wrong during reset");
        end

    // First cycle out of reset
    reset_exit: assert property (@(posedge clk_i) $rose(rstn_i) |-> !full_i && !finish_i.valid)
        else begin
            fail_cnt++;
            $error("outputs wrong after reset release");
        end

    // Finish only from a live, woken head, never from an empty queue
    finish_head: assert property (@(posedge clk_i) disable iff (!rstn_i)
        finish_i.valid |-> head_entry_i.occupied && head_entry_i.ready
                           && count_i != '0)
        else begin
            fail_cnt++;
            $error("finish without a ready head");
        end

    // Full exactly at five live slots when not flushing
    full_level: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !flush_i |-> full_i == (live_cnt >= FULL_LEVEL))
        else begin
            fail_cnt++;
            $error("full_o does not follow the occupancy");
        end

    count_max: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_i <= pmrq_pkg::PMRQ_NUM_ENTRIES)
        else begin
            fail_cnt++;
            $error("count above depth");
        end

    // Empty after flush, full only if flushing again
    flush_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> count_i == '0 && finish_i == '0 && full_i == flush_i)
        else begin
            fail_cnt++;
            $error("queue not empty after flush");
        end

    // Write and retire cancel
    write_retire: assert property (@(posedge clk_i) disable iff (!rstn_i)
        write_en_i && advance_en_i |=> count_i == $past(count_i))
        else begin
            fail_cnt++;
            $error("count moved on write with retire");
        end

endmodule

bind pending_mem_req_queue pmrq_assertions u_assert (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .flush_i      (flush_i),
    .full_i       (full_o),
    .finish_i     (finish_instr_o),
    .count_i      (u_alloc.count),
    .write_en_i   (write_en),
    .advance_en_i (advance_en),
    .head_entry_i (u_retire.head_entry),
    .entries_i    (entries)
);

// ==== testbench/clk_gen.sv ====
// ==============================
// Testbench clock and reset
// 20 ns clock, active-low reset for 8 cycles
// ==============================

module clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;       // 20 ns period
    end

    initial begin
        rstn_o <= 1'b0;                   // Falling edge seen by every reset flop
        repeat (8) @(posedge clk_o);
        rstn_o <= 1'b1;                   // Release on the eighth rising edge
    end

endmodule

// ==== pmrq/pending_mem_req_queue.sv ====
// ==============================
// Pending memory request queue, top level
// Allocator, one slot per entry in a generate loop, retire block
// Missed memory instructions wait here for their replay
// ==============================

module pending_mem_req_queue (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  pmrq_pkg::mem_instr_t          instruction_i,  // From memory stage, level
    input  logic [pmrq_pkg::TAG_W-1:0]    tag_i,          // Physical destination tag
    input  pmrq_pkg::replay_t             replay_i,       // From cache, one-cycle strobe
    input  logic                          flush_i,        // Empty the queue
    input  logic                          advance_head_i, // Retire the head
    output pmrq_pkg::mem_instr_t          finish_instr_o, // To write-back
    output logic                          full_o          // Back-pressure
);

    // Allocator to entries
    logic                                  write_en;
    logic [pmrq_pkg::PMRQ_NUM_ENTRIES-1:0] write_sel;

    // Retire block to allocator and entries
    logic                                  advance_en;
    logic [pmrq_pkg::PMRQ_NUM_ENTRIES-1:0] free_sel;

    // Entries to retire block
    pmrq_pkg::pmrq_entry_t                 entries [pmrq_pkg::PMRQ_NUM_ENTRIES];

    // Tail, count and full flag
    pmrq_alloc u_alloc (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instruction_i.valid),
        .flush_i       (flush_i),
        .advance_en_i  (advance_en),
        .write_en_o    (write_en),
        .write_sel_o   (write_sel),
        .full_o        (full_o)
    );

    // Slots
    // Each sees every replay, only the tail slot sees the write
    for (genvar i = 0; i < pmrq_pkg::PMRQ_NUM_ENTRIES; i++) begin : gen_entry
        pmrq_entry u_entry (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .write_i  (write_en & write_sel[i]),
            .instr_i  (instruction_i),
            .tag_i    (tag_i),
            .replay_i (replay_i),
            .free_i   (free_sel[i]),
            .flush_i  (flush_i),
            .entry_o  (entries[i])
        );
    end

    // Head, finish and retire grant
    pmrq_retire u_retire (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .entries_i      (entries),
        .advance_head_i (advance_head_i),
        .flush_i        (flush_i),
        .advance_en_o   (advance_en),
        .free_sel_o     (free_sel),
        .finish_instr_o (finish_instr_o)
    );

endmodule

// ==== pmrq/pmrq_retire.sv ====
// ==============================
// Retire side of the pending memory request queue
// Head pointer and head slot select
// Finish output and advance enable
// ==============================

module pmrq_retire (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  pmrq_pkg::pmrq_entry_t                 entries_i [pmrq_pkg::PMRQ_NUM_ENTRIES],
    input  logic                                  advance_head_i, // Pipeline retires head
    input  logic                                  flush_i,        // Empty the queue
    output logic                                  advance_en_o,   // Retire granted
    output logic [pmrq_pkg::PMRQ_NUM_ENTRIES-1:0] free_sel_o,     // One-hot slot to free
    output pmrq_pkg::mem_instr_t                  finish_instr_o  // Oldest woken request
);

    logic [pmrq_pkg::PMRQ_PTR_W-1:0] head;        // Oldest slot
    pmrq_pkg::pmrq_entry_t           head_entry;  // Contents at head
    logic                            head_done;   // Head woken and live

    assign head_entry = entries_i[head];
    assign head_done  = head_entry.occupied & head_entry.ready;

    // Finish presents only a live, woken head, otherwise all zero
    assign finish_instr_o = head_done ? head_entry.instr : '0;

    // Retire needs a live head, ready is left to the pipeline
    assign advance_en_o = advance_head_i & head_entry.occupied & ~flush_i;

    // One-hot free of the head slot
    always_comb begin
        for (int i = 0; i < pmrq_pkg::PMRQ_NUM_ENTRIES; i++) begin
            free_sel_o[i] = advance_en_o & (head == pmrq_pkg::PMRQ_PTR_W'(i));
        end
    end

    // Head pointer, wraps with the tail
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head <= '0;
        end else if (flush_i) begin
            head <= '0;                        // Back in line with the tail
        end else if (advance_en_o) begin
            head <= head + pmrq_pkg::PMRQ_PTR_W'(1);
        end
    end

endmodule

// ==== pmrq/pmrq_entry.sv ====
// ==============================
// One slot of the pending memory request queue
// Holds instruction and tag, matches replays
// Keeps the ready and occupied bits
// ==============================

module pmrq_entry (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          write_i,    // Load a new request
    input  pmrq_pkg::mem_instr_t          instr_i,    // Incoming instruction
    input  logic [pmrq_pkg::TAG_W-1:0]    tag_i,      // Its destination tag
    input  pmrq_pkg::replay_t             replay_i,   // Cache replay strobe
    input  logic                          free_i,     // Head retires this slot
    input  logic                          flush_i,    // Drop everything
    output pmrq_pkg::pmrq_entry_t         entry_o     // Slot contents to retire side
);

    pmrq_pkg::mem_instr_t          instr_q;     // Stored instruction
    logic [pmrq_pkg::TAG_W-1:0]    tag_q;       // Stored tag
    logic                          ready_q;     // Woken
    logic                          occupied_q;  // Live request
    logic                          replay_hit;  // Replay targets this slot

    // Only a live slot may be woken
    // A freed slot with an old tag stays quiet
    assign replay_hit = replay_i.valid & occupied_q & (replay_i.tag == tag_q);

    // Control bits
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            occupied_q <= 1'b0;
            ready_q    <= 1'b0;
        end else if (flush_i) begin
            occupied_q <= 1'b0;
            ready_q    <= 1'b0;
        end else if (write_i) begin
            occupied_q <= 1'b1;
            ready_q    <= 1'b0;               // Waits for its replay
        end else if (free_i) begin
            occupied_q <= 1'b0;
            ready_q    <= 1'b0;
        end else if (replay_hit) begin
            ready_q    <= 1'b1;
        end
    end

    // Payload
    // A write in the same cycle as a matching replay is not woken
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            instr_q <= instr_i;
            tag_q   <= tag_i;
        end else if (replay_hit) begin
            instr_q.data_rs2 <= replay_i.data;  // Replayed data replaces rs2
        end
    end

    assign entry_o = '{
        instr:    instr_q,
        tag:      tag_q,
        ready:    ready_q,
        occupied: occupied_q
    };

endmodule

// ==== pmrq/pmrq_alloc.sv ====
// ==============================
// Allocation side of the pending memory request queue
// Tail pointer, occupancy count, write accept
// One-hot slot select and the full flag
// ==============================

module pmrq_alloc (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,
    input  logic                                 instr_valid_i,  // Pipeline offers an instr
    input  logic                                 flush_i,        // Empty the queue
    input  logic                                 advance_en_i,   // Head retires this cycle
    output logic                                 write_en_o,     // Slot at tail loads
    output logic [pmrq_pkg::PMRQ_NUM_ENTRIES-1:0] write_sel_o,   // One-hot tail slot
    output logic                                 full_o          // Back-pressure to pipeline
);

    // Count level at which full_o rises
    localparam logic [pmrq_pkg::PMRQ_CNT_W-1:0] FULL_LEVEL =
        pmrq_pkg::PMRQ_CNT_W'(pmrq_pkg::PMRQ_NUM_ENTRIES - pmrq_pkg::PMRQ_FULL_MARGIN);

    localparam logic [pmrq_pkg::PMRQ_CNT_W-1:0] MAX_COUNT =
        pmrq_pkg::PMRQ_CNT_W'(pmrq_pkg::PMRQ_NUM_ENTRIES);

    logic [pmrq_pkg::PMRQ_PTR_W-1:0] tail;     // Next free slot
    logic [pmrq_pkg::PMRQ_CNT_W-1:0] count;    // Occupied slots
    logic                            has_room; // At least one slot free

    assign has_room = (count < MAX_COUNT);

    // Accept only with room left, flush wins over a write
    assign write_en_o = instr_valid_i & has_room & ~flush_i;

    // Decode tail into a one-hot select
    always_comb begin
        for (int i = 0; i < pmrq_pkg::PMRQ_NUM_ENTRIES; i++) begin
            write_sel_o[i] = (tail == pmrq_pkg::PMRQ_PTR_W'(i));
        end
    end

    // Tail moves with every accepted write and wraps at the depth
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            tail <= '0;
        end else if (flush_i) begin
            tail <= '0;
        end else if (write_en_o) begin
            tail <= tail + pmrq_pkg::PMRQ_PTR_W'(1);
        end
    end

    // Occupancy count
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            count <= '0;
        end else if (flush_i) begin
            count <= '0;                       // Every slot freed at once
        end else begin
            case ({write_en_o, advance_en_i})
                2'b10:   count <= count + pmrq_pkg::PMRQ_CNT_W'(1);
                2'b01:   count <= count - pmrq_pkg::PMRQ_CNT_W'(1);
                default: count <= count;        // Idle, or write and retire cancel
            endcase
        end
    end

    // Raised early so instructions already in flight still fit
    // Also high while flushing and while in reset
    assign full_o = (count >= FULL_LEVEL) | flush_i | ~rstn_i;

endmodule

// ==== common/pmrq_pkg.sv ====
// ==============================
// Shared definitions of the pending memory request queue
// Queue depth, pointer and count widths, full margin
// Memory op encoding, instruction, replay and slot structs
// ==============================

package pmrq_pkg;

    // Queue geometry
    localparam int PMRQ_NUM_ENTRIES = 8;     // Number of slots
    localparam int PMRQ_PTR_W       = 3;     // Head and tail width
    localparam int PMRQ_CNT_W       = 4;     // One bit over the pointers, holds 0..8
    localparam int PMRQ_FULL_MARGIN = 3;     // Spare slots for instructions in flight

    // Datapath widths
    localparam int TAG_W  = 7;               // Physical register tag
    localparam int DATA_W = 64;              // Store data and load result
    localparam int ADDR_W = 40;              // Physical address

    // Memory operation kinds
    // Bit 3 marks a store, the low bits give the access size
    typedef enum logic [3:0] {
        MEM_LB = 4'h0,                       // Load byte
        MEM_LH = 4'h1,                       // Load half
        MEM_LW = 4'h2,                       // Load word
        MEM_LD = 4'h3,                       // Load double
        MEM_SB = 4'h8,                       // Store byte
        MEM_SH = 4'h9,                       // Store half
        MEM_SW = 4'hA,                       // Store word
        MEM_SD = 4'hB                        // Store double
    } mem_op_t;

    // One memory instruction as the memory stage sees it
    typedef struct packed {
        logic              valid;            // Instruction present
        logic [4:0]        rd;               // Architectural destination
        mem_op_t           mem_op;           // Access kind
        logic [ADDR_W-1:0] addr;             // Physical address
        logic [DATA_W-1:0] data_rs2;         // Store data, or load data after replay
    } mem_instr_t;

    // Line replay from the cache
    // Strobe for one cycle, wakes every waiting slot with the same tag
    typedef struct packed {
        logic              valid;            // Replay this cycle
        logic [TAG_W-1:0]  tag;              // Tag of the waking request
        logic [DATA_W-1:0] data;             // Replayed data
    } replay_t;

    // Contents of one queue slot
    typedef struct packed {
        mem_instr_t        instr;            // Stored instruction
        logic [TAG_W-1:0]  tag;              // Physical destination tag
        logic              ready;            // Woken by a replay
        logic              occupied;         // Slot holds a live request
    } pmrq_entry_t;

endpackage
